// ==== common/oramPkg.sv ====
/*
 * Shared geometry, DRAM command codes and bundled types for the Path ORAM
 * address generator. Modules import it inside their body.
 */

`default_nettype none

package oramPkg;

	// ========================================
	// tree geometry
	// ========================================

	localparam int ORAML = 7;                // leaf width, deepest level index
	localparam int NumLevels = ORAML + 1;    // root through leaf
	localparam int LevelWidth = 4;           // holds 0..NumLevels

	// ========================================
	// bucket layout in DRAM
	// ========================================

	localparam int BktBursts = 4;            // whole bucket
	localparam int HdrBursts = 1;            // header only
	localparam int BurstWidth = 2;           // burst counter width
	localparam int BurstLen = 8;             // address step per burst
	localparam int PhysBktWidth = 9;         // 255 buckets in subtree order

	// DRAM command port
	localparam int DdrAddrWidth = 16;
	localparam int DdrCmdWidth = 3;
	localparam logic [DdrCmdWidth-1:0] DdrCmdWrite = DdrCmdWidth'(0);
	localparam logic [DdrCmdWidth-1:0] DdrCmdRead = DdrCmdWidth'(1);

	// ========================================
	// bundled types
	// ========================================

	// one path request from the backend controller
	typedef struct packed {
		logic isRead;                        // 1 read, 0 write
		logic headerOnly;                    // 1 header, 0 whole bucket
		logic [ORAML-1:0] leaf;              // msb picks the first branch
	} pathReqT;

	// current position on the path
	typedef struct packed {
		logic [LevelWidth-1:0] level;        // 0 is root
		logic [NumLevels-1:0] logicalIdx;    // heap order, children 2i+1 and 2i+2
		logic [PhysBktWidth-1:0] physIdx;    // subtree order
	} walkStepT;

	// one burst command toward the DRAM controller
	typedef struct packed {
		logic [DdrCmdWidth-1:0] cmd;
		logic [DdrAddrWidth-1:0] addr;
	} dramCmdT;

endpackage

`default_nettype wire

// ==== hw/dramCmdIssue.sv ====
/*
 * Result stage. Counts bursts within the current bucket and forms one DRAM
 * command per burst. Advances only on accepted transfers and flags the end
 * of each bucket for the walker.
 */

`timescale 1ns/1ps
`default_nettype none

module dramCmdIssue (
	input logic Clock,
	input logic rstN,
	input logic busy,                            // path in progress
	input logic pathStart,
	input logic CmdReady,
	input oramPkg::pathReqT curReq,
	input logic [oramPkg::PhysBktWidth-1:0] physIdx,
	output logic CmdValid,
	output oramPkg::dramCmdT dramCmd,
	output logic levelDone
);

	import oramPkg::*;

	logic [BurstWidth-1:0] burstCnt;
	logic [BurstWidth-1:0] burstLast;
	logic lastBurst;
	logic xfer;
	logic [DdrAddrWidth-1:0] burstIdx;

	// ========================================
	// handshake and bucket end
	// ========================================

	assign CmdValid = busy;                      // level, held under back-pressure
	assign xfer = CmdValid & CmdReady;

	// header mode touches only the first burst of a bucket
	assign burstLast = curReq.headerOnly ? BurstWidth'(HdrBursts - 1)
		: BurstWidth'(BktBursts - 1);
	assign lastBurst = (burstCnt == burstLast);

	assign levelDone = xfer & lastBurst;         // one pulse per bucket

	// ========================================
	// burst counter
	// ========================================

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			burstCnt <= '0;
		end else if (pathStart) begin
			burstCnt <= '0;
		end else if (xfer) begin
			burstCnt <= lastBurst ? '0 : burstCnt + 1'b1;   // wrap into next bucket
		end
	end

	// ========================================
	// command formation
	// ========================================

	// burst number across the whole tree
	assign burstIdx = DdrAddrWidth'(physIdx) * DdrAddrWidth'(BktBursts)
		+ DdrAddrWidth'(burstCnt);

	assign dramCmd.addr = burstIdx * DdrAddrWidth'(BurstLen);
	assign dramCmd.cmd = curReq.isRead ? DdrCmdRead : DdrCmdWrite;

endmodule

`default_nettype wire

// ==== hw/oramAddrGen.sv ====
/*
 * Path ORAM address generator top. Takes one path request and issues the DRAM
 * burst commands for every bucket from root to leaf.
 */

`timescale 1ns/1ps
`default_nettype none

module oramAddrGen (
	input logic Clock,
	input logic rstN,

	// backend controller
	input logic Start,
	input oramPkg::pathReqT req,
	output logic Ready,

	// DRAM command port
	input logic CmdReady,
	output logic CmdValid,
	output oramPkg::dramCmdT dramCmd,

	// debug view of the walk
	output oramPkg::walkStepT step
);

	import oramPkg::*;

	pathReqT curReq;
	logic busy;
	logic pathStart;
	logic pathDone;
	logic levelDone;
	logic [LevelWidth-1:0] walkLevel;
	logic [NumLevels-1:0] walkIdx;
	logic [PhysBktWidth-1:0] walkPhys;

	// ========================================
	// decode
	// ========================================

	pathReqDecode reqDecode (
		.Clock(Clock),
		.rstN(rstN),
		.Start(Start),
		.req(req),
		.Ready(Ready),
		.pathDone(pathDone),
		.busy(busy),
		.pathStart(pathStart),
		.curReq(curReq)
	);

	// ========================================
	// execute
	// ========================================

	pathWalker walker (
		.Clock(Clock),
		.rstN(rstN),
		.pathStart(pathStart),
		.levelDone(levelDone),
		.leaf(curReq.leaf),
		.level(walkLevel),
		.logicalIdx(walkIdx),
		.pathDone(pathDone)
	);

	subtreeMapper mapper (
		.level(walkLevel),
		.leaf(curReq.leaf),
		.physIdx(walkPhys)
	);

	assign step = '{level: walkLevel, logicalIdx: walkIdx, physIdx: walkPhys};

	// ========================================
	// result
	// ========================================

	dramCmdIssue cmdIssue (
		.Clock(Clock),
		.rstN(rstN),
		.busy(busy),
		.pathStart(pathStart),
		.CmdReady(CmdReady),
		.curReq(curReq),
		.physIdx(walkPhys),
		.CmdValid(CmdValid),
		.dramCmd(dramCmd),
		.levelDone(levelDone)
	);

endmodule

`default_nettype wire

// ==== hw/pathReqDecode.sv ====
/*
 * Request decode stage. Accepts a path request while idle, holds it for the
 * whole walk and keeps the busy flag until the leaf bucket is done.
 */

`timescale 1ns/1ps
`default_nettype none

module pathReqDecode (
	input logic Clock,
	input logic rstN,

	// backend controller side
	input logic Start,
	input oramPkg::pathReqT req,
	output logic Ready,

	// toward execute and result stages
	input logic pathDone,
	output logic busy,
	output logic pathStart,
	output oramPkg::pathReqT curReq
);

	import oramPkg::*;

	// ========================================
	// start qualification
	// ========================================

	// the only place Start is looked at
	assign Ready = ~busy;
	assign pathStart = Start & Ready;     // Start while busy is dropped

	// ========================================
	// busy flag
	// ========================================

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			busy <= 1'b0;
		end else if (pathStart) begin
			busy <= 1'b1;                 // Ready falls at the accepting edge
		end else if (pathDone) begin
			busy <= 1'b0;                 // edge that takes the last burst
		end
	end

	// ========================================
	// request register
	// ========================================

	// payload only, held steady for the whole path
	always_ff @(posedge Clock) begin
		if (pathStart) begin
			curReq <= req;
		end
	end

endmodule

`default_nettype wire

// ==== hw/pathWalk/pathWalker.sv ====
/*
 * Execute stage level walker. Steps from the root bucket to the leaf bucket,
 * one level per finished bucket, and tracks the heap index of the bucket.
 */

`timescale 1ns/1ps
`default_nettype none

module pathWalker (
	input logic Clock,
	input logic rstN,
	input logic pathStart,                    // restart at the root
	input logic levelDone,                    // last burst of a bucket taken
	input logic [oramPkg::ORAML-1:0] leaf,
	output logic [oramPkg::LevelWidth-1:0] level,
	output logic [oramPkg::NumLevels-1:0] logicalIdx,
	output logic pathDone
);

	import oramPkg::*;

	logic lastLevel;
	logic [ORAML-1:0] leafShift;
	logic goRight;
	logic [NumLevels-1:0] childIdx;

	// ========================================
	// branch selection
	// ========================================

	assign lastLevel = (level == LevelWidth'(ORAML));

	// leaf bit for the next level sits at the msb after the shift
	assign leafShift = leaf << level;
	assign goRight = leafShift[ORAML-1];

	// left child 2i+1, right child 2i+2
	assign childIdx = (logicalIdx << 1) + NumLevels'(1) + NumLevels'(goRight);

	// same cycle as the leaf bucket's final transfer
	assign pathDone = levelDone & lastLevel;

	// ========================================
	// level and heap index registers
	// ========================================

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			level <= '0;
			logicalIdx <= '0;
		end else if (pathStart) begin
			level <= '0;                      // root
			logicalIdx <= '0;
		end else if (levelDone && !lastLevel) begin
			level <= level + 1'b1;
			logicalIdx <= childIdx;
		end
	end

	// leaf position is held once the path is finished

endmodule

`default_nettype wire

// ==== hw/pathWalk/subtreeMapper.sv ====
/*
 * Execute stage layout mapper. Turns a level on the leaf's path into the
 * physical bucket index of the two-level subtree layout. Pure logic.
 */

`timescale 1ns/1ps
`default_nettype none

module subtreeMapper (
	input logic [oramPkg::LevelWidth-1:0] level,
	input logic [oramPkg::ORAML-1:0] leaf,
	output logic [oramPkg::PhysBktWidth-1:0] physIdx
);

	import oramPkg::*;

	logic [LevelWidth-1:0] band;
	logic [LevelWidth-1:0] shAmt;
	logic [ORAML-1:0] leafTop;
	logic [ORAML-1:0] leafNext;
	logic [PhysBktWidth-1:0] bandBase;
	logic [PhysBktWidth-1:0] subtreeBase;
	logic [PhysBktWidth-1:0] offset;

	// ========================================
	// band and subtree
	// ========================================

	assign band = level >> 1;                        // two levels per band
	assign shAmt = LevelWidth'(ORAML) - (band << 1);

	// subtree number is the leaf prefix above the band
	assign leafTop = leaf >> shAmt;

	// 4^b - 1 buckets live in the bands above
	assign bandBase = (PhysBktWidth'(1) << (band << 1)) - 1'b1;

	// three buckets per subtree, stored back to back
	assign subtreeBase = (PhysBktWidth'(leafTop) << 1) + PhysBktWidth'(leafTop);

	// ========================================
	// position inside the subtree
	// ========================================

	// branch bit below the subtree root, used at odd levels
	assign leafNext = leaf >> (shAmt - 1'b1);

	// root 0, left child 1, right child 2
	assign offset = level[0] ? PhysBktWidth'(leafNext[0]) + 1'b1 : '0;

	assign physIdx = bandBase + subtreeBase + offset;

endmodule

`default_nettype wire

// ==== oramAddrGen.f ====
+incdir+tests
common/oramPkg.sv
hw/pathReqDecode.sv
hw/pathWalk/pathWalker.sv
hw/pathWalk/subtreeMapper.sv
hw/dramCmdIssue.sv
hw/oramAddrGen.sv
tests/oramAddrGenTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
# Exit status is 0 only when the pass line is found.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f oramAddrGen.f \
	--top-module oramAddrGenTb \
	-o oramAddrGenSim > "$BUILD_LOG" 2>&1 \
	|| { cat "$BUILD_LOG"; echo "build failed"; exit 1; }

./obj_dir/oramAddrGenSim > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

grep -q "^Verification passed$" "$SIM_LOG" \
	&& { echo "simulation result: PASS"; exit 0; } \
	|| { echo "simulation result: FAIL"; exit 1; }

// ==== tests/oramAddrGenTasks.svh ====
/*
 * Directed tests for the address generator, included into the testbench
 * module. runPath drives one request and checks the whole command stream.
 */

`ifndef ORAM_ADDR_GEN_TASKS_SVH
`define ORAM_ADDR_GEN_TASKS_SVH

	// one path sampled mid-cycle where a transfer lands at the next rising edge
	task automatic runPath(input logic isRd, input logic hdr, input logic [ORAML-1:0] leaf,
			input bit stall, input bit poke);
		int bursts;
		int nCmd;
		int got;
		int cycles;
		int lvl;
		int phys;
		int addr;
		bit held;
		dramCmdT heldCmd;
		logic nextReady;
		bursts = hdr ? HdrBursts : BktBursts;
		nCmd = NumLevels * bursts;
		got = 0;
		cycles = 0;
		held = 1'b0;
		@(negedge Clock);
		checkVal("Ready", 1, int'(Ready));
		@(posedge Clock);
		Start <= 1'b1;
		req <= '{isRead: isRd, headerOnly: hdr, leaf: leaf};
		@(posedge Clock);                            // accepting edge
		nextReady = stall ? takeBit() : 1'b1;
		Start <= poke;
		if (poke) req <= '{isRead: ~isRd, headerOnly: ~hdr, leaf: ~leaf};   // must not stick
		CmdReady <= nextReady;
		while (got < nCmd) begin
			@(negedge Clock);
			cycles++;
			if (cycles > 24 * nCmd + 16) abortRun("timeout waiting for the path's commands");
			checkVal("Ready", 0, int'(Ready));
			checkVal("CmdValid", 1, int'(CmdValid));
			if (held) checkVal("dramCmd", int'(heldCmd), int'(dramCmd));
			held = !CmdReady;
			heldCmd = dramCmd;
			if (CmdReady) begin
				lvl = got / bursts;
				phys = modelPhys(lvl, leaf);
				addr = modelAddr(phys, got % bursts);
				checkVal("step.level", lvl, int'(step.level));
				checkVal("step.logicalIdx", modelHeap(lvl, leaf), int'(step.logicalIdx));
				checkVal("step.physIdx", phys, int'(step.physIdx));
				checkVal("dramCmd.cmd", int'(isRd ? DdrCmdRead : DdrCmdWrite), int'(dramCmd.cmd));
				checkVal("dramCmd.addr", addr, int'(dramCmd.addr));
				if (trackOwners) noteOwner(int'(dramCmd.addr), int'(step.logicalIdx));
				got++;
			end
			@(posedge Clock);
			nextReady = stall ? takeBit() : 1'b1;
			Start <= poke && (got < nCmd);           // dropped before Ready returns
			CmdReady <= nextReady;
		end
		@(negedge Clock);
		checkVal("Ready", 1, int'(Ready));           // rose at the last transfer
		checkVal("CmdValid", 0, int'(CmdValid));
	endtask

	// one address may belong to one logical bucket only
	task automatic noteOwner(input int addr, input int heap);
		if (addrOwner.exists(addr)) begin
			assert (addrOwner[addr] == heap) else abortRun($sformatf(
				"address 0x%0h is shared by logical buckets %0d and %0d",
				addr, addrOwner[addr], heap));
		end
		addrOwner[addr] = heap;
	endtask

	task automatic checkIdleAfterReset();
		@(negedge Clock);
		checkVal("Ready", 1, int'(Ready));
		checkVal("CmdValid", 0, int'(CmdValid));
		checkVal("UUT.levelDone", 0, int'(UUT.levelDone));
		checkVal("UUT.pathDone", 0, int'(UUT.pathDone));
	endtask

	task automatic fullPathBackToBack();
		runPath(1'b1, 1'b0, 7'h2A, 1'b0, 1'b0);
	endtask

	task automatic wholeBucketReads();
		foreach (pathLeaves[i]) runPath(1'b1, 1'b0, ORAML'(pathLeaves[i]), 1'b0, 1'b0);
	endtask

	task automatic headerOnlyWrites();
		foreach (pathLeaves[i]) runPath(1'b0, 1'b1, ORAML'(pathLeaves[i]), 1'b0, 1'b0);
	endtask

	// same expected stream as the back-to-back reads
	task automatic readsUnderBackPressure();
		foreach (pathLeaves[i]) runPath(1'b1, 1'b0, ORAML'(pathLeaves[i]), 1'b1, 1'b0);
	endtask

	task automatic startWhileBusyIgnored();
		runPath(1'b1, 1'b0, 7'h4C, 1'b0, 1'b1);
		runPath(1'b0, 1'b1, 7'h13, 1'b1, 1'b1);
	endtask

	task automatic headerAddressesUnique();
		int lf;
		addrOwner.delete();
		trackOwners = 1'b1;
		for (lf = 0; lf < (1 << ORAML); lf++) begin
			runPath(1'b1, 1'b1, ORAML'(lf), 1'b0, 1'b0);
		end
		trackOwners = 1'b0;
		checkVal("bucket count", (1 << NumLevels) - 1, addrOwner.num());   // whole tree seen
	endtask

`endif

// ==== tests/oramAddrGenTb.sv ====
/*
 * Testbench for the Path ORAM address generator. Drives path requests, acts
 * as the DRAM command sink and checks every burst against a reference model.
 */

`timescale 1ns/1ps
`default_nettype none

module oramAddrGenTb;

	import oramPkg::*;

	logic Clock;
	logic rstN;
	logic Start;
	pathReqT req;
	logic Ready;
	logic CmdReady;
	logic CmdValid;
	dramCmdT dramCmd;
	walkStepT step;

	logic [15:0] lfsrState;                  // back-pressure source
	int addrOwner [int];                     // address to logical bucket
	bit trackOwners;                         // on during the uniqueness sweep
	int pathLeaves [5] = '{0, 127, 85, 42, 25};

	oramAddrGen UUT (
		.Clock(Clock),
		.rstN(rstN),
		.Start(Start),
		.req(req),
		.Ready(Ready),
		.CmdReady(CmdReady),
		.CmdValid(CmdValid),
		.dramCmd(dramCmd),
		.step(step)
	);

	// ========================================
	// clock
	// ========================================

	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;          // 20 ns period
	end

	// ========================================
	// failure reporting
	// ========================================

	task automatic abortRun(input string why);
		if (why != "") $display("%s", why);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkVal(input string name, input int expVal, input int actVal);
		assert (expVal == actVal) else begin
			$display("** Error at %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, expVal, actVal);
			abortRun("");
		end
	endtask

	// ========================================
	// LFSR and reference model
	// ========================================

	// x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	function automatic logic takeBit();
		lfsrState = {lfsrState[14:0],
			lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10]};
		return lfsrState[0];
	endfunction

	// two-level bands of three-bucket subtrees stored back to back
	function automatic int modelPhys(input int lvl, input logic [ORAML-1:0] leaf);
		int b;
		int sub;
		int off;
		b = lvl / 2;
		sub = int'(leaf) >> (ORAML - 2 * b);
		off = 0;                             // subtree root at even level
		if (lvl % 2 == 1) off = 1 + ((int'(leaf) >> (ORAML - 2 * b - 1)) & 1);
		return (1 << (2 * b)) - 1 + 3 * sub + off;
	endfunction

	// heap walk where the leaf msb picks the first branch
	function automatic int modelHeap(input int lvl, input logic [ORAML-1:0] leaf);
		int idx;
		idx = 0;
		for (int j = 0; j < lvl; j++) begin
			idx = 2 * idx + 1 + int'(leaf[ORAML-1-j]);
		end
		return idx;
	endfunction

	function automatic int modelAddr(input int phys, input int burst);
		return (phys * BktBursts + burst) * BurstLen;
	endfunction

	`include "oramAddrGenTasks.svh"

	// ========================================
	// test sequence
	// ========================================

	initial begin
		Start = 1'b0;
		req = '0;
		CmdReady = 1'b0;
		rstN = 1'b0;
		lfsrState = 16'd56231;
		trackOwners = 1'b0;
		repeat (8) @(posedge Clock);         // reset held for 8 cycles
		rstN <= 1'b1;
		checkIdleAfterReset();
		fullPathBackToBack();
		wholeBucketReads();
		headerOnlyWrites();
		readsUnderBackPressure();
		startWhileBusyIgnored();
		headerAddressesUnique();
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire
